// File: hdl/display_timing.sv
/*
 * display timing: free-running raster counters with registered
 * de, syncs and a frame pulse aligned to the scan position
 */
module display_timing
    import video_pkg::*;
(
    input  logic  clk_pix,
    input  logic  rst_n,
    output scan_t scan
);

    coord_t nx;   // position for the next cycle
    coord_t ny;

    always_comb begin
        if (scan.sx == H_TOTAL - 1'b1) begin
            nx = '0;
            ny = (scan.sy == V_TOTAL - 1'b1) ? '0 : scan.sy + 1'b1;
        end else begin
            nx = scan.sx + 1'b1;
            ny = scan.sy;
        end
    end

    // decode from the next position so flags line up with sx/sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            scan       <= '0;
            scan.de    <= 1'b1;   // (0,0) is an active pixel
            scan.frame <= 1'b1;
        end else begin
            scan.sx    <= nx;
            scan.sy    <= ny;
            scan.de    <= (nx < H_ACTIVE) && (ny < V_ACTIVE);
            scan.hsync <= (nx >= H_SYNC_START) && (nx < H_SYNC_END);
            scan.vsync <= (ny == V_SYNC_LINE);
            scan.frame <= (nx == '0) && (ny == '0);
        end
    end

    // counters never leave the raster
    a_scan_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (scan.sx < H_TOTAL) && (scan.sy < V_TOTAL)
    );

endmodule

// File: hdl/draw_line.sv
/*
 * line engine: latches a command, waits for the next frame start,
 * then walks the Bresenham line writing one pixel per cycle
 */
module draw_line
    import video_pkg::*;
    import draw_pkg::*;
(
    input  logic      clk_pix,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      cmd_strobe,
    input  logic      frame,
    output logic      we,
    output coord_t    wx,
    output coord_t    wy,
    output cidx_t     wcidx,
    output logic      busy,
    output logic      done
);

    typedef enum logic [1:0] {IDLE, PENDING, DRAW, DONE} state_t;
    typedef logic signed [CORDW+2:0] err_t;   // room for 2*err

    state_t    state;
    line_cmd_t cmd_q;
    err_t      dx;       // |x1-x0|
    err_t      dy;       // -|y1-y0|
    err_t      err;
    err_t      e2;
    logic      x_inc;    // step directions
    logic      y_inc;
    coord_t    x;
    coord_t    y;
    logic      accept;
    logic      last;

    assign accept = cmd_strobe && (state == IDLE || state == DONE);
    assign last   = (x == cmd_q.x1) && (y == cmd_q.y1);
    assign e2     = err <<< 1;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE, DONE: state <= accept ? PENDING : IDLE;
                PENDING:    if (frame) state <= DRAW;   // start on a frame boundary
                DRAW:       if (last) state <= DONE;
                default:    state <= IDLE;
            endcase
        end
    end

    // walk registers
    always_ff @(posedge clk_pix) begin
        if (accept) begin
            cmd_q <= cmd;
            dx    <= (cmd.x1 >= cmd.x0) ? err_t'(cmd.x1 - cmd.x0) : err_t'(cmd.x0 - cmd.x1);
            dy    <= (cmd.y1 >= cmd.y0) ? -err_t'(cmd.y1 - cmd.y0) : -err_t'(cmd.y0 - cmd.y1);
            x_inc <= (cmd.x1 >= cmd.x0);
            y_inc <= (cmd.y1 >= cmd.y0);
        end
        if (state == PENDING && frame) begin
            x   <= cmd_q.x0;
            y   <= cmd_q.y0;
            err <= dx + dy;
        end else if (state == DRAW) begin
            if (e2 >= dy) begin
                x <= x_inc ? x + 1'b1 : x - 1'b1;
            end
            if (e2 <= dx) begin
                y <= y_inc ? y + 1'b1 : y - 1'b1;
            end
            err <= err + ((e2 >= dy) ? dy : '0) + ((e2 <= dx) ? dx : '0);
        end
    end

    assign we    = (state == DRAW);
    assign wx    = x;
    assign wy    = y;
    assign wcidx = cmd_q.cidx;
    assign busy  = (state == PENDING) || (state == DRAW);
    assign done  = (state == DONE);   // one cycle, after the last pixel

    // the walk never overshoots the endpoints of the latched command
    a_write_in_box: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        we |-> (x_inc ? (wx >= cmd_q.x0 && wx <= cmd_q.x1)
                      : (wx <= cmd_q.x0 && wx >= cmd_q.x1))
            && (y_inc ? (wy >= cmd_q.y0 && wy <= cmd_q.y1)
                      : (wy <= cmd_q.y0 && wy >= cmd_q.y1))
    );

endmodule

// File: hdl/draw_pkg.sv
/*
 * drawing definitions: framebuffer geometry, colour index,
 * line command and the 16 entry 12-bit palette
 */
package draw_pkg;
    import video_pkg::*;

    localparam int FB_WIDTH       = 32;
    localparam int FB_HEIGHT      = 24;
    localparam int FB_SCALE_SHIFT = 1;   // scale 2 on scanout
    localparam int FB_ADDRW       = $clog2(FB_WIDTH * FB_HEIGHT);

    localparam int CIDXW = 4;
    typedef logic [CIDXW-1:0] cidx_t;

    // one line request, endpoints inclusive
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        cidx_t  cidx;
    } line_cmd_t;

    typedef struct packed {
        logic [CHANW-1:0] red;
        logic [CHANW-1:0] green;
        logic [CHANW-1:0] blue;
    } rgb_t;

    // entry 0 is the background
    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h235, 12'h725, 12'h085, 12'hA53, 12'h655, 12'hCCC, 12'hFFE,
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3, 12'h2AF, 12'h879, 12'hF7A, 12'hFCA
    };

endpackage

// File: hdl/framebuffer.sv
/*
 * framebuffer: 32x24 colour index memory, written by the line
 * engine and read at half resolution for scanout
 */
module framebuffer
    import video_pkg::*;
    import draw_pkg::*;
(
    input  logic   clk_pix,
    input  logic   rst_n,
    input  scan_t  scan,
    input  logic   we,
    input  coord_t wx,
    input  coord_t wy,
    input  cidx_t  wcidx,
    output cidx_t  cidx,
    output scan_t  sync    // scan delayed to match cidx
);

    cidx_t mem [FB_WIDTH * FB_HEIGHT];

    coord_t rx;
    coord_t ry;

    function automatic logic [FB_ADDRW-1:0] addr_of(coord_t x, coord_t y);
        return FB_ADDRW'(y) * FB_ADDRW'(FB_WIDTH) + FB_ADDRW'(x);
    endfunction

    initial begin
        for (int i = 0; i < FB_WIDTH * FB_HEIGHT; i++) begin
            mem[i] = '0;   // blank canvas
        end
    end

    assign rx = scan.sx >> FB_SCALE_SHIFT;
    assign ry = scan.sy >> FB_SCALE_SHIFT;

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_of(wx, wy)] <= wcidx;
        end
        if (scan.de) begin
            cidx <= mem[addr_of(rx, ry)];
        end else begin
            cidx <= '0;   // blanking reads as background
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sync <= '0;
        end else begin
            sync <= scan;
        end
    end

    // line engine has no clipping, so its writes must land inside
    a_write_in_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        we |-> (wx < FB_WIDTH) && (wy < FB_HEIGHT)
    );

endmodule

// File: hdl/line_frame_top.sv
/*
 * line plotter top: timing, framebuffer and palette in a two-stage
 * pixel pipeline, with the line engine writing the framebuffer
 */
module line_frame_top
    import video_pkg::*;
    import draw_pkg::*;
(
    input  logic      clk_pix,
    input  logic      rst_n,
    input  line_cmd_t cmd,
    input  logic      cmd_strobe,
    output video_t    video,
    output logic      busy,
    output logic      done
);

    scan_t  scan;
    scan_t  fb_sync;
    cidx_t  fb_cidx;
    logic   fb_we;
    coord_t fb_wx;
    coord_t fb_wy;
    cidx_t  fb_wcidx;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scan    (scan)
    );

    draw_line u_draw (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .frame      (scan.frame),
        .we         (fb_we),
        .wx         (fb_wx),
        .wy         (fb_wy),
        .wcidx      (fb_wcidx),
        .busy       (busy),
        .done       (done)
    );

    framebuffer u_fb (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .scan    (scan),
        .we      (fb_we),
        .wx      (fb_wx),
        .wy      (fb_wy),
        .wcidx   (fb_wcidx),
        .cidx    (fb_cidx),
        .sync    (fb_sync)
    );

    palette_out u_palette (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .cidx    (fb_cidx),
        .sync    (fb_sync),
        .video   (video)
    );

endmodule

// File: hdl/palette_out.sv
/*
 * palette output: maps a colour index to 12-bit RGB and registers
 * it together with the delayed sync bits
 */
module palette_out
    import video_pkg::*;
    import draw_pkg::*;
(
    input  logic   clk_pix,
    input  logic   rst_n,
    input  cidx_t  cidx,
    input  scan_t  sync,
    output video_t video
);

    rgb_t rgb;

    always_comb begin
        rgb = sync.de ? PALETTE[cidx] : '0;   // black in blanking
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            video <= '0;
        end else begin
            video.red   <= rgb.red;
            video.green <= rgb.green;
            video.blue  <= rgb.blue;
            video.hsync <= sync.hsync;
            video.vsync <= sync.vsync;
            video.de    <= sync.de;
            video.frame <= sync.frame;
        end
    end

endmodule

// File: hdl/video_pkg.sv
/*
 * video raster definitions: reduced 80x52 scan geometry,
 * coordinate type and the structs carried along the pixel path
 */
package video_pkg;

    localparam int CORDW = 8;   // coordinate width
    localparam int CHANW = 4;   // colour channel width

    typedef logic [CORDW-1:0] coord_t;

    // horizontal timing, in pixels
    localparam coord_t H_ACTIVE     = 64;
    localparam coord_t H_SYNC_START = 68;
    localparam coord_t H_SYNC_END   = 71;   // first pixel after sync
    localparam coord_t H_TOTAL      = 80;

    // vertical timing, in lines
    localparam coord_t V_ACTIVE    = 48;
    localparam coord_t V_SYNC_LINE = 49;
    localparam coord_t V_TOTAL     = 52;

    // scan position plus control bits (20 bits)
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;
        logic   frame;
    } scan_t;

    // final video output (16 bits)
    typedef struct packed {
        logic [CHANW-1:0] red;
        logic [CHANW-1:0] green;
        logic [CHANW-1:0] blue;
        logic             hsync;
        logic             vsync;
        logic             de;
        logic             frame;
    } video_t;

endpackage

// File: run.sh
#!/bin/sh
# build the line plotter testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_line_frame \
    -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_line_frame)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

// File: tb.f
hdl/video_pkg.sv
hdl/draw_pkg.sv
hdl/display_timing.sv
hdl/framebuffer.sv
hdl/draw_line.sv
hdl/palette_out.sv
hdl/line_frame_top.sv
test/tb_line_frame.sv

// File: test/tb_line_frame.sv
/*
 * line plotter testbench: draws a table of lines, mirrors them in a
 * shadow framebuffer and checks every pixel of the following frame
 */
module tb_line_frame
    import video_pkg::*;
    import draw_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_TOT = int'(H_TOTAL);
    localparam int H_ACT = int'(H_ACTIVE);
    localparam int V_ACT = int'(V_ACTIVE);
    localparam int FRAME_CYCLES = H_TOT * int'(V_TOTAL);
    localparam int CLK_HALF_NS = 10;
    localparam int N_STEPS = 6;

    typedef struct packed {
        line_cmd_t cmd;
        logic      extra;   // second strobe while busy
    } step_t;

    logic      clk_pix;
    logic      rst_n;
    line_cmd_t cmd;
    logic      cmd_strobe;
    video_t    video;
    logic      busy;
    logic      done;

    step_t     steps [N_STEPS];
    cidx_t     shadow [FB_HEIGHT][FB_WIDTH];
    line_cmd_t ignored_cmd;
    int        errors = 0;
    int        done_count = 0;

    line_frame_top dut (
        .clk_pix    (clk_pix),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .video      (video),
        .busy       (busy),
        .done       (done)
    );

    initial begin
        clk_pix = 1'b0;
        forever #CLK_HALF_NS clk_pix = ~clk_pix;
    end

    // up to three frames per line plus the blank frame and slack
    initial begin : watchdog
        longint limit_ns;
        limit_ns = longint'(3 * (N_STEPS + 1) + 2) * FRAME_CYCLES * 2 * CLK_HALF_NS;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    always @(negedge clk_pix) begin
        if (rst_n && done) done_count++;   // counts high cycles, not edges
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    function automatic step_t make_step(input int x0, input int y0, input int x1,
                                        input int y1, input int c, input logic extra);
        step_t s;
        s.cmd.x0   = coord_t'(x0);
        s.cmd.y0   = coord_t'(y0);
        s.cmd.x1   = coord_t'(x1);
        s.cmd.y1   = coord_t'(y1);
        s.cmd.cidx = cidx_t'(c);
        s.extra    = extra;
        return s;
    endfunction

    function automatic int line_length(input line_cmd_t c);
        int adx;
        int ady;
        adx = (c.x1 >= c.x0) ? int'(c.x1) - int'(c.x0) : int'(c.x0) - int'(c.x1);
        ady = (c.y1 >= c.y0) ? int'(c.y1) - int'(c.y0) : int'(c.y0) - int'(c.y1);
        return ((adx > ady) ? adx : ady) + 1;
    endfunction

    // reference Bresenham walk into the shadow buffer
    function automatic void plot_shadow(input line_cmd_t c);
        int x;
        int y;
        int dx;
        int dy;
        int err;
        int e2;
        x   = int'(c.x0);
        y   = int'(c.y0);
        dx  = (c.x1 >= c.x0) ? int'(c.x1) - x : x - int'(c.x1);
        dy  = (c.y1 >= c.y0) ? y - int'(c.y1) : int'(c.y1) - y;   // negative
        err = dx + dy;
        forever begin
            shadow[y][x] = c.cidx;
            if (x == int'(c.x1) && y == int'(c.y1)) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x += (c.x1 >= c.x0) ? 1 : -1;
            end
            if (e2 <= dx) begin
                err += dx;
                y += (c.y1 >= c.y0) ? 1 : -1;
            end
        end
    endfunction

    // position comes from counting de on the output only
    task automatic check_frame();
        int   px;
        int   py;
        int   h;
        int   v;
        rgb_t exp_rgb;
        rgb_t got_rgb;
        px = 0;
        py = 0;
        do begin
            @(negedge clk_pix);
        end while (!video.frame);
        for (int c = 0; c < FRAME_CYCLES; c++) begin
            if (c > 0) @(negedge clk_pix);
            h = c % H_TOT;
            v = c / H_TOT;
            check_value("video.frame", 32'(video.frame), 32'(c == 0));
            check_value("video.de", 32'(video.de), 32'(h < H_ACT && v < V_ACT));
            check_value("video.hsync", 32'(video.hsync),
                        32'(h >= int'(H_SYNC_START) && h < int'(H_SYNC_END)));
            check_value("video.vsync", 32'(video.vsync), 32'(v == int'(V_SYNC_LINE)));
            exp_rgb = '0;   // blanking is black
            if (video.de) begin
                if (px < H_ACT && py < V_ACT) begin
                    exp_rgb = PALETTE[shadow[py >> FB_SCALE_SHIFT][px >> FB_SCALE_SHIFT]];
                end
                px++;
            end
            got_rgb = {video.red, video.green, video.blue};
            check_value("video.red/green/blue", 32'(got_rgb), 32'(exp_rgb));
            if (h == H_TOT - 1 && px > 0) begin
                check_value("active pixels per line", px, H_ACT);
                py++;
                px = 0;
            end
        end
        check_value("active lines", py, V_ACT);
        @(negedge clk_pix);
        check_value("video.frame period", 32'(video.frame), 32'(1'b1));
    endtask

    initial begin : main
        step_t s;
        int    since_frame;
        int    len;
        rst_n      = 1'b0;
        cmd        = '0;
        cmd_strobe = 1'b0;
        foreach (shadow[y, x]) shadow[y][x] = '0;
        steps[0] = make_step(2, 3, 20, 3, 3, 1'b0);     // horizontal
        steps[1] = make_step(5, 1, 5, 20, 8, 1'b0);     // vertical
        steps[2] = make_step(1, 2, 30, 12, 11, 1'b1);   // shallow, with a stray strobe
        steps[3] = make_step(28, 1, 20, 22, 12, 1'b0);  // steep, right to left
        steps[4] = make_step(16, 12, 16, 12, 15, 1'b0); // single point
        steps[5] = make_step(0, 3, 25, 3, 9, 1'b0);     // over the horizontal one
        s = make_step(0, 23, 31, 0, 7, 1'b0);
        ignored_cmd = s.cmd;   // colour 7 is never drawn

        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        check_value("busy", 32'(busy), 32'(1'b0));
        check_value("done", 32'(done), 32'(1'b0));
        check_value("video", 32'(video), 32'(0));
        @(posedge clk_pix);
        rst_n <= 1'b1;

        check_frame();   // blank canvas
        check_value("done pulses", done_count, 0);

        foreach (steps[i]) begin
            s = steps[i];
            while (busy) @(negedge clk_pix);
            @(posedge clk_pix);
            cmd        <= s.cmd;
            cmd_strobe <= 1'b1;
            @(posedge clk_pix);
            if (s.extra) cmd <= ignored_cmd;
            else cmd_strobe <= 1'b0;
            @(negedge clk_pix);
            if (s.extra) begin
                check_value("busy", 32'(busy), 32'(1'b1));
                @(posedge clk_pix);
                cmd_strobe <= 1'b0;
                @(negedge clk_pix);
            end
            since_frame = -1;   // no output frame seen yet
            forever begin
                if (video.frame) since_frame = 0;
                else if (since_frame >= 0) since_frame++;
                if (done) break;
                check_value("busy", 32'(busy), 32'(1'b1));
                @(negedge clk_pix);
            end
            check_value("busy", 32'(busy), 32'(1'b0));
            len = line_length(s.cmd);
            // output frame lags the scan by 2, first pixel is 1 after the scan frame
            check_value("done delay after video.frame", since_frame, len - 1);
            plot_shadow(s.cmd);
            check_frame();
            check_value("done pulses", done_count, i + 1);
        end

        $display("checks finished: %0d errors, %0d done pulses", errors, done_count);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
